// File: all.f
+incdir+common
common/fetch_pkg.sv
hw/fetch_stage.sv
icache/icache_array.sv
icache/icache_fill_fsm.sv
hw/fetch_top.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

// File: common/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

////////////////////////////////////////
// fetch front end widths and geometry
////////////////////////////////////////

// byte address width of the core
`define PC_WIDTH 32

// one instruction word
`define INST_WIDTH 32

// first address fetched out of reset
`define RESET_PC 32'h0000_0000

// direct mapped, 16 lines of one 8 byte block each
`define ICACHE_INDEX_BITS 4

`endif

// File: common/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

	////////////////////////////////////////
	// plain vectors
	////////////////////////////////////////
	typedef logic [`PC_WIDTH-1:0]                     pc_t;            // byte address
	typedef logic [`INST_WIDTH-1:0]                   inst_t;          // one instruction
	typedef logic [2*`INST_WIDTH-1:0]                 fetch_block_t;   // lower word = lower address
	typedef logic [`ICACHE_INDEX_BITS-1:0]            icache_index_t;  // line select
	typedef logic [`PC_WIDTH-`ICACHE_INDEX_BITS-4:0]  icache_tag_t;    // above index and 3 offset bits

	////////////////////////////////////////
	// grouped signals
	////////////////////////////////////////
	typedef struct packed {
		pc_t   pc;            // block address of the pair
		inst_t inst1;         // instruction at pc
		inst_t inst2;         // instruction at pc + 4
		logic  inst1_valid;
		logic  inst2_valid;
	} fetch_bundle_t;

	typedef struct packed {
		logic valid;          // branch mispredicted, restart fetch
		pc_t  target;         // may point at either word of a block
	} redirect_t;

	typedef struct packed {
		logic rs;             // reservation station full
		logic rob;            // reorder buffer full
		logic rat;            // free list empty
		logic structural;     // memory port busy with data access
	} backend_stall_t;

	// miss handling states
	typedef enum logic [1:0] {
		FILL_IDLE  = 2'd0,
		FILL_ADDR  = 2'd1,
		FILL_DATA  = 2'd2,
		FILL_WRITE = 2'd3
	} fill_state_t;

endpackage

// File: hw/fetch_stage.sv
`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetch_stage (
	input  logic                      clock,
	input  logic                      reset,
	input  fetch_pkg::redirect_t      redirect,   // from the back end
	input  fetch_pkg::backend_stall_t stall,
	input  logic                      hit,        // same cycle cache answer
	input  fetch_pkg::fetch_block_t   block,
	output fetch_pkg::pc_t            fetch_pc,   // lookup address
	output fetch_pkg::fetch_bundle_t  bundle      // to decode
);
	import fetch_pkg::*;

	pc_t   pc_q;
	pc_t   pc_next;
	logic  upper_entry_q;      // next bundle enters at the second slot
	logic  upper_entry_next;
	logic  stall_any;
	logic  advance;            // hit taken into the bundle register this cycle
	logic  inst1_valid_q;
	logic  inst2_valid_q;
	pc_t   bundle_pc_q;
	inst_t inst1_q;
	inst_t inst2_q;

	////////////////////////////////////////
	// stall merge and next pc
	////////////////////////////////////////
	assign stall_any = stall.rs | stall.rob | stall.rat | stall.structural;
	assign advance   = hit & ~stall_any & ~redirect.valid;

	always_comb
	begin
		pc_next          = pc_q;             // hold by default (stall or miss)
		upper_entry_next = upper_entry_q;
		if (redirect.valid)
		begin
			// redirect wins over stall and hit, fetch the whole block
			pc_next          = {redirect.target[`PC_WIDTH-1:3], 3'b000};
			upper_entry_next = redirect.target[2];   // remember which slot is live
		end
		else if (advance)
		begin
			pc_next          = pc_q + pc_t'(8);
			upper_entry_next = 1'b0;                  // only the first block is partial
		end
	end

	assign fetch_pc = pc_q;

	////////////////////////////////////////
	// control registers
	////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc_q          <= pc_t'(`RESET_PC);
			upper_entry_q <= 1'b0;
			inst1_valid_q <= 1'b0;
			inst2_valid_q <= 1'b0;
		end
		else
		begin
			pc_q          <= pc_next;
			upper_entry_q <= upper_entry_next;
			if (redirect.valid)
			begin
				inst1_valid_q <= 1'b0;           // wrong path bundle dropped
				inst2_valid_q <= 1'b0;
			end
			else if (!stall_any)
			begin
				// old bundle was taken; load a new one or go empty on a miss
				inst1_valid_q <= advance & ~upper_entry_q;
				inst2_valid_q <= advance;
			end
		end
	end

	// bundle payload, only moves on a taken hit
	always_ff @(posedge clock)
	begin
		if (advance)
		begin
			bundle_pc_q <= pc_q;
			inst1_q     <= block[`INST_WIDTH-1:0];
			inst2_q     <= block[2*`INST_WIDTH-1:`INST_WIDTH];
		end
	end

	assign bundle = '{
		pc:          bundle_pc_q,
		inst1:       inst1_q,
		inst2:       inst2_q,
		inst1_valid: inst1_valid_q,
		inst2_valid: inst2_valid_q
	};

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
	input  logic                      clock,
	input  logic                      reset,
	input  fetch_pkg::redirect_t      redirect,
	input  fetch_pkg::backend_stall_t stall,
	output fetch_pkg::fetch_bundle_t  bundle,
	// AXI4-Lite read master
	output fetch_pkg::pc_t            araddr,
	output logic                      arvalid,
	input  logic                      arready,
	input  fetch_pkg::inst_t          rdata,
	input  logic [1:0]                rresp,
	input  logic                      rvalid,
	output logic                      rready
);
	import fetch_pkg::*;

	pc_t          fetch_pc;     // stage to array and fill machine
	logic         hit;
	fetch_block_t block;
	logic         fill_valid;   // fill machine to array write port
	pc_t          fill_pc;
	fetch_block_t fill_block;

	////////////////////////////////////////
	// pc, stall merge, output bundle
	////////////////////////////////////////
	fetch_stage u_fetch_stage (
		.clock    (clock),
		.reset    (reset),
		.redirect (redirect),
		.stall    (stall),
		.hit      (hit),
		.block    (block),
		.fetch_pc (fetch_pc),
		.bundle   (bundle)
	);

	icache_array u_icache_array (
		.clock      (clock),
		.reset      (reset),
		.lookup_pc  (fetch_pc),
		.hit        (hit),
		.block      (block),
		.fill_valid (fill_valid),
		.fill_pc    (fill_pc),
		.fill_block (fill_block)
	);

	// miss side, talks to memory
	icache_fill_fsm u_icache_fill_fsm (
		.clock      (clock),
		.reset      (reset),
		.hit        (hit),
		.miss_pc    (fetch_pc),
		.stall      (stall),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.fill_valid (fill_valid),
		.fill_pc    (fill_pc),
		.fill_block (fill_block)
	);

endmodule

// File: icache/icache_array.sv
`timescale 1ns/100ps
`include "fetch_defs.svh"

module icache_array (
	input  logic                    clock,
	input  logic                    reset,
	input  fetch_pkg::pc_t          lookup_pc,    // current fetch address
	output logic                    hit,
	output fetch_pkg::fetch_block_t block,
	input  logic                    fill_valid,   // one cycle line write
	input  fetch_pkg::pc_t          fill_pc,
	input  fetch_pkg::fetch_block_t fill_block
);
	import fetch_pkg::*;

	localparam int LINES       = 1 << `ICACHE_INDEX_BITS;
	localparam int OFFSET_BITS = 3;                        // 8 byte blocks
	localparam int TAG_LSB     = OFFSET_BITS + `ICACHE_INDEX_BITS;

	icache_tag_t      tag_mem  [LINES];
	fetch_block_t     data_mem [LINES];
	logic [LINES-1:0] valid_q;                             // one bit per line

	icache_index_t lookup_index;
	icache_tag_t   lookup_tag;
	icache_index_t fill_index;
	icache_tag_t   fill_tag;

	////////////////////////////////////////
	// address split
	////////////////////////////////////////
	assign lookup_index = lookup_pc[OFFSET_BITS +: `ICACHE_INDEX_BITS];
	assign lookup_tag   = lookup_pc[`PC_WIDTH-1:TAG_LSB];
	assign fill_index   = fill_pc[OFFSET_BITS +: `ICACHE_INDEX_BITS];
	assign fill_tag     = fill_pc[`PC_WIDTH-1:TAG_LSB];

	// lookup answers in the same cycle
	assign hit   = valid_q[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
	assign block = data_mem[lookup_index];   // don't care on a miss

	////////////////////////////////////////
	// line state
	////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
			valid_q <= '0;                   // cold cache
		else if (fill_valid)
			valid_q[fill_index] <= 1'b1;
	end

	// tag and data store, overwritten whole on a fill
	always_ff @(posedge clock)
	begin
		if (fill_valid)
		begin
			tag_mem[fill_index]  <= fill_tag;
			data_mem[fill_index] <= fill_block;
		end
	end

endmodule

// File: icache/icache_fill_fsm.sv
`timescale 1ns/100ps
`include "fetch_defs.svh"

module icache_fill_fsm (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      hit,
	input  fetch_pkg::pc_t            miss_pc,     // address that missed
	input  fetch_pkg::backend_stall_t stall,
	// AXI4-Lite read address channel
	output fetch_pkg::pc_t            araddr,
	output logic                      arvalid,
	input  logic                      arready,
	// AXI4-Lite read data channel
	input  fetch_pkg::inst_t          rdata,
	input  logic [1:0]                rresp,       // not looked at by fetch
	input  logic                      rvalid,
	output logic                      rready,
	// line write into the array
	output logic                      fill_valid,
	output fetch_pkg::pc_t            fill_pc,
	output fetch_pkg::fetch_block_t   fill_block
);
	import fetch_pkg::*;

	fill_state_t  state_q;
	fill_state_t  state_next;
	logic         beat_q;         // 0 lower word, 1 upper word
	pc_t          block_addr_q;   // 8 byte aligned miss address
	fetch_block_t block_q;        // line being assembled
	logic         stall_any;
	logic         start_fill;
	logic         beat_done;      // data beat accepted this cycle

	assign stall_any  = stall.rs | stall.rob | stall.rat | stall.structural;
	assign start_fill = (state_q == FILL_IDLE) && !hit && !stall_any;
	assign beat_done  = (state_q == FILL_DATA) && rvalid;

	////////////////////////////////////////
	// next state
	////////////////////////////////////////
	always_comb
	begin
		state_next = state_q;
		case (state_q)
			FILL_IDLE:  if (start_fill) state_next = FILL_ADDR;
			FILL_ADDR:  if (arready)    state_next = FILL_DATA;   // address taken
			FILL_DATA:
			begin
				if (rvalid)
					state_next = beat_q ? FILL_WRITE : FILL_ADDR;  // second word ends it
			end
			FILL_WRITE: state_next = FILL_IDLE;                      // line written here
			default:    state_next = FILL_IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state_q <= FILL_IDLE;
			beat_q  <= 1'b0;
		end
		else
		begin
			state_q <= state_next;
			if (start_fill)
				beat_q <= 1'b0;
			else if (beat_done && !beat_q)
				beat_q <= 1'b1;          // move on to pc + 4
		end
	end

	////////////////////////////////////////
	// address latch and line assembly
	////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (start_fill)
			block_addr_q <= {miss_pc[`PC_WIDTH-1:3], 3'b000};
		if (beat_done)
		begin
			if (beat_q)
				block_q[2*`INST_WIDTH-1:`INST_WIDTH] <= rdata;
			else
				block_q[`INST_WIDTH-1:0] <= rdata;
		end
	end

	// held registers keep araddr stable while arvalid waits
	assign araddr     = {block_addr_q[`PC_WIDTH-1:3], beat_q, 2'b00};
	assign arvalid    = (state_q == FILL_ADDR);
	assign rready     = (state_q == FILL_DATA);
	assign fill_valid = (state_q == FILL_WRITE);   // single cycle pulse
	assign fill_pc    = block_addr_q;
	assign fill_block = block_q;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module fetch_tb -o fetch_sim

output=$(./obj_dir/fetch_sim)
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
	exit 0
else
	exit 1
fi

// File: verification/fetch_checker.sv
`timescale 1ns/100ps
`include "fetch_defs.svh"

module fetch_checker (
	input  logic                      clock,
	input  logic                      reset,
	input  fetch_pkg::redirect_t      redirect,
	input  fetch_pkg::backend_stall_t stall,
	input  fetch_pkg::fetch_bundle_t  bundle,
	input  fetch_pkg::pc_t            araddr,
	input  logic                      arvalid,
	input  logic                      arready,
	input  logic                      rvalid,
	input  logic                      rready,
	output int                        bundle_errors,
	output int                        axi_errors,
	output int                        accepted_count   // bundles taken by decode so far
);
	import fetch_pkg::*;

	localparam logic [15:0] MARKER = 16'hA5C3;   // upper half of every memory word

	pc_t           expected_pc;     // next block the accepted stream must show
	logic          expect_upper;    // first bundle after a redirect into the upper word
	logic          stall_seen;      // stall was high at the previous edge
	fetch_bundle_t prev_bundle;
	logic          ar_pending;      // arvalid high and not yet taken
	pc_t           prev_araddr;
	logic          beat;            // set once the lower word address was taken
	pc_t           fill_base;
	logic          r_outstanding;   // read address taken and data not yet returned
	logic [15:0]   line_valid;      // shadow of the cache contents
	icache_tag_t   line_tag [16];
	logic          reset_checked;
	logic          stall_any;
	logic          bundle_valid;

	// word stored at byte address a
	function automatic inst_t expected_word(pc_t a);
		return {MARKER, a[15:0]};
	endfunction

	function automatic logic resident(pc_t a);
		return line_valid[a[6:3]] && (line_tag[a[6:3]] == a[31:7]);
	endfunction

	task automatic compare_bundle(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected)
		begin
			$display("** Error: %s = %h, expected %h", name, got, expected);
			bundle_errors++;
		end
	endtask

	task automatic check_axi(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected)
		begin
			$display("** Error: %s = %h, expected %h", name, got, expected);
			axi_errors++;
		end
	endtask

	always @(posedge clock)
	begin
		if (reset)
		begin
			expected_pc    = pc_t'(`RESET_PC);
			expect_upper   = 1'b0;
			stall_seen     = 1'b0;
			ar_pending     = 1'b0;
			beat           = 1'b0;
			r_outstanding  = 1'b0;
			line_valid     = '0;       // cache is cold after reset
			reset_checked  = 1'b0;
			bundle_errors  = 0;
			axi_errors     = 0;
			accepted_count = 0;
		end
		else
		begin
			stall_any    = stall.rs | stall.rob | stall.rat | stall.structural;
			bundle_valid = bundle.inst1_valid | bundle.inst2_valid;

			////////////////////////////////////////
			// idle outputs right after reset
			if (!reset_checked)
			begin
				reset_checked = 1'b1;
				compare_bundle("bundle valid bits", {30'b0, bundle.inst1_valid,
					bundle.inst2_valid}, 32'h0);
				check_axi("arvalid", {31'b0, arvalid}, 32'h0);
			end

			// a stalled bundle must not move
			if (stall_seen && (bundle !== prev_bundle))
			begin
				$display("** Error: bundle = %h, expected %h", bundle, prev_bundle);
				bundle_errors++;
			end

			if (redirect.valid)
			begin
				expected_pc  = {redirect.target[31:3], 3'b000};   // wrong path flushed
				expect_upper = redirect.target[2];
			end
			else if (bundle_valid && !stall_any)
			begin
				compare_bundle("bundle.pc", bundle.pc, expected_pc);
				compare_bundle("bundle.inst1_valid", {31'b0, bundle.inst1_valid},
					{31'b0, ~expect_upper});
				compare_bundle("bundle.inst2_valid", {31'b0, bundle.inst2_valid}, 32'h1);
				if (!expect_upper)
					compare_bundle("bundle.inst1", bundle.inst1, expected_word(expected_pc));
				compare_bundle("bundle.inst2", bundle.inst2, expected_word(expected_pc + 4));
				expected_pc  = expected_pc + 8;
				expect_upper = 1'b0;
				accepted_count++;
			end
			stall_seen  = stall_any && !redirect.valid;
			prev_bundle = bundle;

			////////////////////////////////////////
			// read address channel
			if (ar_pending)
			begin
				check_axi("arvalid", {31'b0, arvalid}, 32'h1);   // no drop before arready
				check_axi("araddr", araddr, prev_araddr);
			end
			if (arvalid && arready)
			begin
				if (!beat)
				begin
					check_axi("araddr[2:0]", {29'b0, araddr[2:0]}, 32'h0);
					if (resident(araddr))
					begin
						$display("fill started for block %h that is already in the cache",
							araddr);
						axi_errors++;
					end
					fill_base = araddr;
					beat      = 1'b1;
				end
				else
				begin
					check_axi("araddr", araddr, fill_base + 4);   // upper word second
					beat                     = 1'b0;
					line_valid[fill_base[6:3]] = 1'b1;
					line_tag[fill_base[6:3]]   = fill_base[31:7];
				end
			end
			ar_pending  = arvalid && !arready;
			prev_araddr = araddr;

			// rready only while a read is outstanding
			check_axi("rready", {31'b0, rready}, {31'b0, r_outstanding});
			if (rvalid && rready)
				r_outstanding = 1'b0;
			if (arvalid && arready)
				r_outstanding = 1'b1;
		end
	end

endmodule

// File: verification/fetch_tb.sv
`timescale 1ns/100ps

module fetch_tb;
	import fetch_pkg::*;

	// one table row
	typedef struct packed {
		logic        redirect_valid;
		logic        mid_fill;        // wait for a fill in flight before redirecting
		pc_t         target;
		logic [3:0]  stall_bits;      // rs rob rat structural bits held for 3 cycles
		logic [31:0] count;           // bundles to collect
	} stim_t;

	localparam int ENTRIES = 7;
	localparam logic [15:0] MARKER = 16'hA5C3;

	logic           clock = 1'b0;
	logic           reset;
	redirect_t      redirect;
	backend_stall_t stall;
	fetch_bundle_t  bundle;
	pc_t            araddr;
	logic           arvalid;
	logic           arready = 1'b0;
	inst_t          rdata = '0;
	logic [1:0]     rresp;
	logic           rvalid = 1'b0;
	logic           rready;

	int    bundle_errors;
	int    axi_errors;
	int    accepted_count;
	int    timeout_errors;
	logic  aborted;
	int    seed;
	int    ar_delay;
	int    r_delay;
	logic  rd_pending;
	pc_t   rd_addr;
	stim_t stim_table [ENTRIES];
	stim_t entry;

	always #2 clock = ~clock;   // 4 ns period

	fetch_top dut (
		.clock    (clock),
		.reset    (reset),
		.redirect (redirect),
		.stall    (stall),
		.bundle   (bundle),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready)
	);

	fetch_checker chk (
		.clock          (clock),
		.reset          (reset),
		.redirect       (redirect),
		.stall          (stall),
		.bundle         (bundle),
		.araddr         (araddr),
		.arvalid        (arvalid),
		.arready        (arready),
		.rvalid         (rvalid),
		.rready         (rready),
		.bundle_errors  (bundle_errors),
		.axi_errors     (axi_errors),
		.accepted_count (accepted_count)
	);

	function automatic inst_t memory_word(pc_t a);
		return {MARKER, a[15:0]};
	endfunction

	////////////////////////////////////////
	// AXI4-Lite memory with 0..3 cycle waits
	////////////////////////////////////////
	always @(negedge clock)
	begin
		if (reset)
		begin
			arready    <= 1'b0;
			rvalid     <= 1'b0;
			rd_pending <= 1'b0;
			ar_delay   <= 0;
			r_delay    <= 0;
		end
		else
		begin
			if (arready)
			begin
				arready    <= 1'b0;              // handshake took place at the last edge
				rd_pending <= 1'b1;
				rd_addr    <= araddr;
				r_delay    <= $unsigned($random(seed)) % 4;
				ar_delay   <= $unsigned($random(seed)) % 4;
			end
			else if (arvalid)
			begin
				if (ar_delay == 0)
					arready <= 1'b1;
				else
					ar_delay <= ar_delay - 1;
			end
			if (rvalid)
				rvalid <= 1'b0;                  // rready is high all through FILL_DATA
			else if (rd_pending)
			begin
				if (r_delay == 0)
				begin
					rvalid     <= 1'b1;
					rdata      <= memory_word(rd_addr);
					rd_pending <= 1'b0;
				end
				else
					r_delay <= r_delay - 1;
			end
		end
	end

	task automatic wait_for_fill();
		int cycles;
		cycles = 0;
		while (!(arvalid || rready) && cycles < 100)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!(arvalid || rready))
		begin
			$display("timeout: no cache fill started within 100 cycles");
			timeout_errors++;
			aborted = 1'b1;
		end
	endtask

	task automatic collect_bundles(int n);
		int target;
		int cycles;
		target = accepted_count + n;
		cycles = 0;
		while (accepted_count < target && cycles < 300)
		begin
			@(negedge clock);
			cycles++;
		end
		if (accepted_count < target)
		begin
			$display("timeout: only %0d of %0d bundles arrived", accepted_count, target);
			timeout_errors++;
			aborted = 1'b1;
		end
	endtask

	initial
	begin
		seed           = 10;
		reset          = 1'b1;
		redirect       = '0;
		stall          = '0;
		rresp          = 2'b00;
		timeout_errors = 0;
		aborted        = 1'b0;
		// redirect, mid fill, target, stall, bundles
		stim_table[0] = '{1'b0, 1'b0, 32'h0000_0000, 4'b0000, 32'd6};   // cold sequential
		stim_table[1] = '{1'b1, 1'b0, 32'h0000_0000, 4'b0000, 32'd2};   // back to a hit
		stim_table[2] = '{1'b0, 1'b0, 32'h0000_0000, 4'b1000, 32'd4};   // rs stall on a held bundle
		stim_table[3] = '{1'b1, 1'b0, 32'h0000_1004, 4'b0010, 32'd3};   // upper slot
		stim_table[4] = '{1'b1, 1'b1, 32'h0000_2000, 4'b0000, 32'd3};   // during a fill
		stim_table[5] = '{1'b1, 1'b0, 32'h0000_2008, 4'b0001, 32'd2};   // resident block
		stim_table[6] = '{1'b1, 1'b0, 32'h0000_300c, 4'b0100, 32'd4};
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		for (int i = 0; i < ENTRIES && !aborted; i++)
		begin
			entry = stim_table[i];
			if (entry.mid_fill)
				wait_for_fill();
			if (entry.redirect_valid && !aborted)
			begin
				redirect = '{valid: 1'b1, target: entry.target};
				@(negedge clock);
				redirect = '0;
			end
			stall = backend_stall_t'(entry.stall_bits);
			repeat (3) @(negedge clock);
			stall = '0;
			if (!aborted)
				collect_bundles(int'(entry.count));
		end

		$display("errors: bundle %0d, axi %0d, timeout %0d",
			bundle_errors, axi_errors, timeout_errors);
		if (bundle_errors + axi_errors + timeout_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
